// File: all.f
rv_pkg.sv
rv_decoder.sv
reg_file.sv
rv_execute.sv
rv_writeback.sv
rv_core.sv
rv_core_assertions.sv
tb_rv_core.sv

// File: reg_file.sv
// 32 x 32 register file, async read, write on rising clk, x0 reads zero
`timescale 1ns/1ps

module reg_file (
    input  logic             clk,
    input  logic             rst,
    input  rv_pkg::reg_idx_t rs1,
    input  rv_pkg::reg_idx_t rs2,
    input  rv_pkg::reg_idx_t rd,
    input  logic             we,
    input  rv_pkg::word_t    wd,
    output rv_pkg::word_t    rd1,
    output rv_pkg::word_t    rd2
);

    rv_pkg::word_t regs [32];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != '0) begin
            regs[rd] <= wd;
        end
    end

    // x0 forced on read as well
    assign rd1 = (rs1 == '0) ? '0 : regs[rs1];
    assign rd2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// File: run.sh
#!/usr/bin/env bash
# build the rv_core testbench with Verilator, run it, and check the log
set -e
set -o pipefail
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --assert --timing --timescale 1ns/1ps \
    --top-module tb_rv_core -f all.f -o sim
./obj_dir/sim +verilator+error+limit+1000 | tee sim.log

if grep -qx "Result: PASSED" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

// File: rv_core.sv
// single-cycle rv32im core; instructions arrive on a strobe, no fetch, csr, division or traps
`timescale 1ns/1ps

module rv_core (
    input  logic            clk,
    input  logic            rst,
    input  rv_pkg::word_t   instr,
    input  logic            instr_valid,
    output rv_pkg::word_t   pc,
    output rv_pkg::retire_t retire
);

    rv_pkg::reg_idx_t rs1_idx;
    rv_pkg::reg_idx_t rs2_idx;
    rv_pkg::reg_idx_t rd_idx;
    rv_pkg::word_t    imm;
    rv_pkg::ctrl_t    ctrl;
    rv_pkg::word_t    rs1_data;
    rv_pkg::word_t    rs2_data;
    rv_pkg::word_t    alu_result;
    rv_pkg::word_t    mul_result;
    rv_pkg::word_t    next_pc;
    rv_pkg::word_t    wb_data;
    logic             wb_we;

    // pc holds while no instruction is presented
    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= rv_pkg::RESET_PC;
        end else if (instr_valid) begin
            pc <= next_pc;
        end
    end

    rv_decoder decoder0 (
        .instr (instr),
        .rs1   (rs1_idx),
        .rs2   (rs2_idx),
        .rd    (rd_idx),
        .imm   (imm),
        .ctrl  (ctrl)
    );

    reg_file reg_file0 (
        .clk (clk),
        .rst (rst),
        .rs1 (rs1_idx),
        .rs2 (rs2_idx),
        .rd  (rd_idx),
        .we  (wb_we),
        .wd  (wb_data),
        .rd1 (rs1_data),
        .rd2 (rs2_data)
    );

    rv_execute execute0 (
        .pc         (pc),
        .imm        (imm),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .ctrl       (ctrl),
        .alu_result (alu_result),
        .mul_result (mul_result),
        .next_pc    (next_pc)
    );

    // write enables gated by instr_valid in here
    rv_writeback writeback0 (
        .clk         (clk),
        .rst         (rst),
        .instr_valid (instr_valid),
        .ctrl        (ctrl),
        .rd          (rd_idx),
        .alu_result  (alu_result),
        .mul_result  (mul_result),
        .store_data  (rs2_data),
        .pc          (pc),
        .wb_data     (wb_data),
        .wb_we       (wb_we),
        .retire      (retire)
    );

endmodule

// File: rv_core_assertions.sv
// reference checks assume naturally aligned loads and stores; a load is checked once every byte it reads was stored
`timescale 1ns/1ps

module rv_core_assertions (
    input logic            clk,
    input logic            rst,
    input rv_pkg::word_t   instr,
    input logic            instr_valid,
    input rv_pkg::word_t   pc,
    input rv_pkg::retire_t retire,
    input rv_pkg::word_t   regs [32]
);

    int fail_count = 0;

    logic [6:0]    op;
    logic [2:0]    f3;
    rv_pkg::word_t rs1v;
    rv_pkg::word_t rs2v;
    rv_pkg::word_t imm_i;
    rv_pkg::word_t imm_s;
    rv_pkg::word_t imm_b;
    rv_pkg::word_t imm_u;
    rv_pkg::word_t imm_j;
    rv_pkg::word_t ld_addr;
    rv_pkg::word_t st_addr;
    rv_pkg::word_t load_val;
    logic          load_ok;
    int            nbytes;
    logic          exp_write;
    logic          data_known;
    rv_pkg::word_t exp_data;
    rv_pkg::word_t exp_pc;

    // byte image of every store seen so far
    logic [7:0] shadow [rv_pkg::DMEM_WORDS * 4];
    logic       shadow_ok [rv_pkg::DMEM_WORDS * 4];

    function automatic rv_pkg::word_t alu_ref(logic [2:0] kind, rv_pkg::word_t a,
                                              rv_pkg::word_t b, logic alt);
        case (kind)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return {31'b0, $signed(a) < $signed(b)};
            3'd3:    return {31'b0, a < b};
            3'd4:    return a ^ b;
            3'd5:    return alt ? rv_pkg::word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    // full 64-bit product, high word for the mulh group
    function automatic rv_pkg::word_t mul_ref(logic [1:0] kind, rv_pkg::word_t a,
                                              rv_pkg::word_t b);
        logic [63:0] wa;
        logic [63:0] wb;
        logic [63:0] p;
        wa = {{32{a[31] && (kind == 2'd1 || kind == 2'd2)}}, a};
        wb = {{32{b[31] && kind == 2'd1}}, b};
        p = wa * wb;
        return (kind == 2'd0) ? p[31:0] : p[63:32];
    endfunction

    function automatic logic branch_ref(logic [2:0] kind, rv_pkg::word_t a, rv_pkg::word_t b);
        case (kind)
            3'd0:    return a == b;
            3'd1:    return a != b;
            3'd4:    return $signed(a) < $signed(b);
            3'd5:    return $signed(a) >= $signed(b);
            3'd6:    return a < b;
            3'd7:    return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    always_comb begin
        logic [rv_pkg::DMEM_AW+1:0] ba;
        rv_pkg::word_t              raw;

        op      = instr[6:0];
        f3      = instr[14:12];
        rs1v    = (instr[19:15] == 5'd0) ? '0 : regs[instr[19:15]];
        rs2v    = (instr[24:20] == 5'd0) ? '0 : regs[instr[24:20]];
        imm_i   = {{20{instr[31]}}, instr[31:20]};
        imm_s   = {{20{instr[31]}}, instr[31:25], instr[11:7]};
        imm_b   = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
        imm_u   = {instr[31:12], 12'b0};
        imm_j   = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
        nbytes  = (f3[1:0] == 2'd0) ? 1 : (f3[1:0] == 2'd1) ? 2 : 4;
        ld_addr = rs1v + imm_i;
        st_addr = rs1v + imm_s;

        // gather load bytes from the shadow image
        raw     = '0;
        load_ok = 1'b1;
        for (int k = 0; k < 4; k++) begin
            ba = {ld_addr[rv_pkg::DMEM_AW+1:2], ld_addr[1:0] + 2'(k)};
            if (k < nbytes) begin
                raw[8*k +: 8] = shadow[ba];
                load_ok       = load_ok & shadow_ok[ba];
            end
        end
        case (nbytes)
            1:       load_val = {{24{!f3[2] && raw[7]}}, raw[7:0]};
            2:       load_val = {{16{!f3[2] && raw[15]}}, raw[15:0]};
            default: load_val = raw;
        endcase

        exp_write  = 1'b0;
        data_known = 1'b0;
        exp_data   = '0;
        exp_pc     = pc + 32'd4;
        case (op)
            rv_pkg::OP_LUI: begin
                exp_write  = 1'b1;
                data_known = 1'b1;
                exp_data   = imm_u;
            end
            rv_pkg::OP_AUIPC: begin
                exp_write  = 1'b1;
                data_known = 1'b1;
                exp_data   = pc + imm_u;
            end
            rv_pkg::OP_JAL: begin
                exp_write  = 1'b1;
                data_known = 1'b1;
                exp_data   = pc + 32'd4;
                exp_pc     = pc + imm_j;
            end
            rv_pkg::OP_JALR: begin
                exp_write  = 1'b1;
                data_known = 1'b1;
                exp_data   = pc + 32'd4;
                exp_pc     = (rs1v + imm_i) & ~32'd1;
            end
            rv_pkg::OP_BRANCH: begin
                if (branch_ref(f3, rs1v, rs2v)) begin
                    exp_pc = pc + imm_b;
                end
            end
            rv_pkg::OP_LOAD: begin
                exp_write  = 1'b1;
                data_known = load_ok;
                exp_data   = load_val;
            end
            rv_pkg::OP_ALUI: begin
                exp_write  = 1'b1;
                data_known = 1'b1;
                exp_data   = alu_ref(f3, rs1v, imm_i, (f3 == 3'd5) && instr[30]);
            end
            rv_pkg::OP_ALU: begin
                data_known = 1'b1;
                if (instr[31:25] == 7'b0000001) begin
                    // division encodings write nothing
                    exp_write = !f3[2];
                    exp_data  = mul_ref(f3[1:0], rs1v, rs2v);
                end else begin
                    exp_write = 1'b1;
                    exp_data  = alu_ref(f3, rs1v, rs2v, instr[30]);
                end
            end
            default: begin
                exp_write = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < rv_pkg::DMEM_WORDS * 4; i++) begin
                shadow_ok[i] <= 1'b0;
            end
        end else if (instr_valid && op == rv_pkg::OP_STORE) begin
            for (int k = 0; k < 4; k++) begin
                if (k < nbytes) begin
                    shadow[{st_addr[rv_pkg::DMEM_AW+1:2], st_addr[1:0] + 2'(k)}] <= rs2v[8*k +: 8];
                    shadow_ok[{st_addr[rv_pkg::DMEM_AW+1:2], st_addr[1:0] + 2'(k)}] <= 1'b1;
                end
            end
        end
    end

    pc_after_reset: assert property (@(posedge clk) disable iff (rst)
        $past(rst) |-> pc == rv_pkg::RESET_PC && !retire.valid)
        else begin
            fail_count++;
            $error("mismatch at %0t: pc 0x%h after reset", $time, pc);
        end

    retire_on_write: assert property (@(posedge clk) disable iff (rst)
        !$past(rst) && $past(instr_valid && exp_write)
        |-> retire.valid && retire.rd == $past(instr[11:7]))
        else begin
            fail_count++;
            $error("mismatch at %0t: retire valid %b rd %0d", $time, retire.valid, retire.rd);
        end

    no_retire_without_write: assert property (@(posedge clk) disable iff (rst)
        !$past(rst) && !$past(instr_valid && exp_write) |-> !retire.valid)
        else begin
            fail_count++;
            $error("unexpected retire pulse at %0t without a writing instruction", $time);
        end

    retire_data: assert property (@(posedge clk) disable iff (rst)
        !$past(rst) && $past(instr_valid && exp_write && data_known)
        |-> retire.data == $past(exp_data))
        else begin
            fail_count++;
            $error("mismatch at %0t: retire data 0x%h expected 0x%h", $time, retire.data,
                   $past(exp_data));
        end

    pc_update: assert property (@(posedge clk) disable iff (rst)
        !$past(rst) && $past(instr_valid) |-> pc == $past(exp_pc))
        else begin
            fail_count++;
            $error("mismatch at %0t: pc 0x%h expected 0x%h", $time, pc, $past(exp_pc));
        end

    pc_hold: assert property (@(posedge clk) disable iff (rst)
        !$past(rst) && !$past(instr_valid) |-> pc == $past(pc))
        else begin
            fail_count++;
            $error("mismatch at %0t: pc moved to 0x%h while idle", $time, pc);
        end

    x0_zero: assert property (@(posedge clk) disable iff (rst) regs[0] == '0)
        else begin
            fail_count++;
            $error("mismatch at %0t: x0 reads 0x%h", $time, regs[0]);
        end

endmodule

// File: rv_decoder.sv
// purely combinational decode; csr, fence, division and unknown opcodes decode as no-ops
`timescale 1ns/1ps

module rv_decoder (
    input  rv_pkg::word_t    instr,
    output rv_pkg::reg_idx_t rs1,
    output rv_pkg::reg_idx_t rs2,
    output rv_pkg::reg_idx_t rd,
    output rv_pkg::word_t    imm,
    output rv_pkg::ctrl_t    ctrl
);

    logic [6:0] funct7;
    logic [2:0] funct3;
    logic [6:0] op;

    rv_pkg::word_t imm_i;
    rv_pkg::word_t imm_s;
    rv_pkg::word_t imm_b;
    rv_pkg::word_t imm_u;
    rv_pkg::word_t imm_j;

    // field splitters
    assign funct7 = instr[31:25];
    assign funct3 = instr[14:12];
    assign op     = instr[6:0];
    assign rs2    = instr[24:20];
    assign rs1    = instr[19:15];
    assign rd     = instr[11:7];

    // immediate formats
    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        // defaults write nothing
        imm                = '0;
        ctrl.a_sel         = rv_pkg::A_ZERO;
        ctrl.b_sel         = rv_pkg::B_IMM;
        ctrl.alu_op        = rv_pkg::ALU_ADD;
        ctrl.sub_arith     = 1'b0;
        ctrl.mul_op        = rv_pkg::MUL_MUL;
        ctrl.branch_instr  = 1'b0;
        ctrl.branch_op     = rv_pkg::BL_BEQ;
        ctrl.branch_always = 1'b0;
        ctrl.jump_reg      = 1'b0;
        ctrl.dmem_write    = 1'b0;
        ctrl.dmem_width    = rv_pkg::WORD;
        ctrl.dmem_sign     = 1'b0;
        ctrl.wb_sel        = rv_pkg::WB_ALU;
        ctrl.wb_write      = 1'b0;

        case (rv_pkg::opcode_t'(op))
            rv_pkg::OP_LUI: begin
                imm           = imm_u;
                ctrl.wb_write = 1'b1;
            end
            rv_pkg::OP_AUIPC: begin
                imm           = imm_u;
                ctrl.a_sel    = rv_pkg::A_PC;
                ctrl.wb_write = 1'b1;
            end
            // jump targets come out of the alu adder
            rv_pkg::OP_JAL: begin
                imm                = imm_j;
                ctrl.a_sel         = rv_pkg::A_PC;
                ctrl.branch_always = 1'b1;
                ctrl.wb_sel        = rv_pkg::WB_PC_PLUS_4;
                ctrl.wb_write      = 1'b1;
            end
            rv_pkg::OP_JALR: begin
                imm                = imm_i;
                ctrl.a_sel         = rv_pkg::A_RS1;
                ctrl.branch_always = 1'b1;
                ctrl.jump_reg      = 1'b1;
                ctrl.wb_sel        = rv_pkg::WB_PC_PLUS_4;
                ctrl.wb_write      = 1'b1;
            end
            rv_pkg::OP_BRANCH: begin
                imm               = imm_b;
                ctrl.a_sel        = rv_pkg::A_PC;
                ctrl.branch_instr = 1'b1;
                ctrl.branch_op    = rv_pkg::branch_op_t'(funct3);
            end
            rv_pkg::OP_LOAD: begin
                imm             = imm_i;
                ctrl.a_sel      = rv_pkg::A_RS1;
                ctrl.dmem_width = rv_pkg::mem_width_t'(funct3[1:0]);
                ctrl.dmem_sign  = !funct3[2];
                ctrl.wb_sel     = rv_pkg::WB_DM;
                ctrl.wb_write   = 1'b1;
            end
            rv_pkg::OP_STORE: begin
                imm             = imm_s;
                ctrl.a_sel      = rv_pkg::A_RS1;
                ctrl.dmem_width = rv_pkg::mem_width_t'(funct3[1:0]);
                ctrl.dmem_write = 1'b1;
            end
            rv_pkg::OP_ALUI: begin
                imm           = imm_i;
                ctrl.a_sel    = rv_pkg::A_RS1;
                ctrl.alu_op   = rv_pkg::alu_op_t'(funct3);
                // bit 30 is immediate data except on srai
                ctrl.sub_arith = (rv_pkg::alu_op_t'(funct3) == rv_pkg::ALU_SRL) && instr[30];
                ctrl.wb_write = 1'b1;
            end
            rv_pkg::OP_ALU: begin
                ctrl.a_sel = rv_pkg::A_RS1;
                ctrl.b_sel = rv_pkg::B_RS2;
                if (funct7 == 7'b0000001) begin
                    // div/rem group left unimplemented
                    ctrl.mul_op   = rv_pkg::mul_op_t'(funct3[1:0]);
                    ctrl.wb_sel   = rv_pkg::WB_MUL;
                    ctrl.wb_write = !funct3[2];
                end else begin
                    ctrl.alu_op    = rv_pkg::alu_op_t'(funct3);
                    ctrl.sub_arith = instr[30];
                    ctrl.wb_write  = 1'b1;
                end
            end
            default: begin
                // fence, system and anything unknown keep the defaults
            end
        endcase
    end

endmodule

// File: rv_execute.sv
// combinational execute; alu adder also forms branch and jump targets, no division
`timescale 1ns/1ps

module rv_execute (
    input  rv_pkg::word_t pc,
    input  rv_pkg::word_t imm,
    input  rv_pkg::word_t rs1_data,
    input  rv_pkg::word_t rs2_data,
    input  rv_pkg::ctrl_t ctrl,
    output rv_pkg::word_t alu_result,
    output rv_pkg::word_t mul_result,
    output rv_pkg::word_t next_pc
);

    rv_pkg::word_t      op_a;
    rv_pkg::word_t      op_b;
    logic [4:0]         shamt;
    rv_pkg::word_t      sra_result;
    logic               a_signed;
    logic               b_signed;
    logic signed [32:0] mul_a;
    logic signed [32:0] mul_b;
    logic signed [63:0] product;
    logic               taken;

    // operand muxes
    always_comb begin
        case (ctrl.a_sel)
            rv_pkg::A_RS1: op_a = rs1_data;
            rv_pkg::A_PC:  op_a = pc;
            default:       op_a = '0;
        endcase
    end

    assign op_b  = (ctrl.b_sel == rv_pkg::B_RS2) ? rs2_data : imm;
    assign shamt = op_b[4:0];

    // kept on its own so the shift stays signed
    assign sra_result = $signed(op_a) >>> shamt;

    always_comb begin
        case (ctrl.alu_op)
            rv_pkg::ALU_ADD:  alu_result = ctrl.sub_arith ? op_a - op_b : op_a + op_b;
            rv_pkg::ALU_SLL:  alu_result = op_a << shamt;
            rv_pkg::ALU_SLT:  alu_result = {31'b0, $signed(op_a) < $signed(op_b)};
            rv_pkg::ALU_SLTU: alu_result = {31'b0, op_a < op_b};
            rv_pkg::ALU_XOR:  alu_result = op_a ^ op_b;
            rv_pkg::ALU_SRL:  alu_result = ctrl.sub_arith ? sra_result : op_a >> shamt;
            rv_pkg::ALU_OR:   alu_result = op_a | op_b;
            default:          alu_result = op_a & op_b;
        endcase
    end

    // 33-bit operands cover signed, unsigned and mixed products
    assign a_signed = (ctrl.mul_op == rv_pkg::MUL_MULH) || (ctrl.mul_op == rv_pkg::MUL_MULHSU);
    assign b_signed = (ctrl.mul_op == rv_pkg::MUL_MULH);
    assign mul_a    = {a_signed & op_a[31], op_a};
    assign mul_b    = {b_signed & op_b[31], op_b};
    assign product  = mul_a * mul_b;

    assign mul_result = (ctrl.mul_op == rv_pkg::MUL_MUL) ? product[31:0] : product[63:32];

    // branch condition on raw register values
    always_comb begin
        case (ctrl.branch_op)
            rv_pkg::BL_BEQ:  taken = rs1_data == rs2_data;
            rv_pkg::BL_BNE:  taken = rs1_data != rs2_data;
            rv_pkg::BL_BLT:  taken = $signed(rs1_data) < $signed(rs2_data);
            rv_pkg::BL_BGE:  taken = $signed(rs1_data) >= $signed(rs2_data);
            rv_pkg::BL_BLTU: taken = rs1_data < rs2_data;
            rv_pkg::BL_BGEU: taken = rs1_data >= rs2_data;
            default:         taken = 1'b0;
        endcase
    end

    always_comb begin
        if (ctrl.branch_always || (ctrl.branch_instr && taken)) begin
            next_pc = ctrl.jump_reg ? {alu_result[31:1], 1'b0} : alu_result;
        end else begin
            next_pc = pc + 32'd4;
        end
    end

endmodule

// File: rv_pkg.sv
// shared rv32im types; no csr types, data memory size must be a power of two
package rv_pkg;

    // sizes
    localparam int DMEM_WORDS = 256;
    localparam int DMEM_AW = $clog2(DMEM_WORDS);
    localparam logic [31:0] RESET_PC = 32'h0000_0000;

    typedef logic [31:0] word_t;
    typedef logic [4:0] reg_idx_t;

    // rv32 major opcodes
    typedef enum logic [6:0] {
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_BRANCH = 7'b1100011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_ALUI   = 7'b0010011,
        OP_ALU    = 7'b0110011,
        OP_FENCE  = 7'b0001111,
        OP_SYSTEM = 7'b1110011
    } opcode_t;

    // encodings follow funct3
    typedef enum logic [2:0] {
        ALU_ADD  = 3'b000,
        ALU_SLL  = 3'b001,
        ALU_SLT  = 3'b010,
        ALU_SLTU = 3'b011,
        ALU_XOR  = 3'b100,
        ALU_SRL  = 3'b101,
        ALU_OR   = 3'b110,
        ALU_AND  = 3'b111
    } alu_op_t;

    typedef enum logic [2:0] {
        BL_BEQ  = 3'b000,
        BL_BNE  = 3'b001,
        BL_BLT  = 3'b100,
        BL_BGE  = 3'b101,
        BL_BLTU = 3'b110,
        BL_BGEU = 3'b111
    } branch_op_t;

    // funct3[1:0] of the M group
    typedef enum logic [1:0] {
        MUL_MUL    = 2'b00,
        MUL_MULH   = 2'b01,
        MUL_MULHSU = 2'b10,
        MUL_MULHU  = 2'b11
    } mul_op_t;

    // funct3[1:0] of loads and stores
    typedef enum logic [1:0] {
        BYTE = 2'b00,
        HALF = 2'b01,
        WORD = 2'b10
    } mem_width_t;

    typedef enum logic [1:0] {A_ZERO, A_RS1, A_PC} a_sel_t;
    typedef enum logic {B_RS2, B_IMM} b_sel_t;
    typedef enum logic [1:0] {WB_ALU, WB_MUL, WB_DM, WB_PC_PLUS_4} wb_sel_t;

    typedef struct packed {
        a_sel_t     a_sel;
        b_sel_t     b_sel;
        alu_op_t    alu_op;
        logic       sub_arith;
        mul_op_t    mul_op;
        logic       branch_instr;
        branch_op_t branch_op;
        logic       branch_always;
        // jalr target comes from rs1
        logic       jump_reg;
        logic       dmem_write;
        mem_width_t dmem_width;
        logic       dmem_sign;
        wb_sel_t    wb_sel;
        logic       wb_write;
    } ctrl_t;

    typedef struct packed {
        logic     valid;
        reg_idx_t rd;
        word_t    data;
    } retire_t;

endpackage

// File: rv_writeback.sv
// data memory wraps modulo its size; misaligned accesses are not trapped
`timescale 1ns/1ps

module rv_writeback (
    input  logic             clk,
    input  logic             rst,
    input  logic             instr_valid,
    input  rv_pkg::ctrl_t    ctrl,
    input  rv_pkg::reg_idx_t rd,
    input  rv_pkg::word_t    alu_result,
    input  rv_pkg::word_t    mul_result,
    input  rv_pkg::word_t    store_data,
    input  rv_pkg::word_t    pc,
    output rv_pkg::word_t    wb_data,
    output logic             wb_we,
    output rv_pkg::retire_t  retire
);

    rv_pkg::word_t dmem [rv_pkg::DMEM_WORDS];

    logic [rv_pkg::DMEM_AW-1:0] dmem_idx;
    logic [1:0]                 byte_off;
    logic [3:0]                 st_mask;
    rv_pkg::word_t              st_data;
    rv_pkg::word_t              ld_shift;
    rv_pkg::word_t              load_data;

    assign dmem_idx = alu_result[rv_pkg::DMEM_AW+1:2];
    assign byte_off = alu_result[1:0];

    // replicate store data onto every lane, mask picks the live ones
    always_comb begin
        case (ctrl.dmem_width)
            rv_pkg::BYTE: begin
                st_data = {4{store_data[7:0]}};
                st_mask = 4'b0001 << byte_off;
            end
            rv_pkg::HALF: begin
                st_data = {2{store_data[15:0]}};
                st_mask = 4'b0011 << {byte_off[1], 1'b0};
            end
            default: begin
                st_data = store_data;
                st_mask = 4'b1111;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < 4; i++) begin
            if (instr_valid && ctrl.dmem_write && st_mask[i]) begin
                dmem[dmem_idx][8*i +: 8] <= st_data[8*i +: 8];
            end
        end
    end

    // load lane down to bit 0
    assign ld_shift = dmem[dmem_idx] >> {byte_off, 3'b000};

    always_comb begin
        case (ctrl.dmem_width)
            rv_pkg::BYTE: load_data = {{24{ctrl.dmem_sign & ld_shift[7]}}, ld_shift[7:0]};
            rv_pkg::HALF: load_data = {{16{ctrl.dmem_sign & ld_shift[15]}}, ld_shift[15:0]};
            default:      load_data = ld_shift;
        endcase
    end

    always_comb begin
        case (ctrl.wb_sel)
            rv_pkg::WB_MUL:       wb_data = mul_result;
            rv_pkg::WB_DM:        wb_data = load_data;
            rv_pkg::WB_PC_PLUS_4: wb_data = pc + 32'd4;
            default:              wb_data = alu_result;
        endcase
    end

    assign wb_we = instr_valid & ctrl.wb_write;

    // one-cycle retire report
    always_ff @(posedge clk) begin
        retire.rd   <= rd;
        retire.data <= wb_data;
        if (rst) begin
            retire.valid <= 1'b0;
        end else begin
            retire.valid <= wb_we;
        end
    end

endmodule

// File: tb_rv_core.sv
// stimulus only; expected values come from the bound checker, aligned memory accesses only
`timescale 1ns/1ps

module tb_rv_core;

    localparam int CLK_PERIOD = 4;
    localparam int N_ALU      = 150;
    localparam int N_MUL      = 60;
    localparam int N_MEM      = 40;
    localparam int N_BRANCH   = 60;
    // directed part is about 80 instructions
    localparam int N_INSTR        = 80 + N_ALU + N_MUL + 2 * N_MEM + N_BRANCH;
    localparam int TIMEOUT_CYCLES = N_INSTR * 4 + 200;

    logic            clk;
    logic            rst;
    rv_pkg::word_t   instr;
    logic            instr_valid;
    rv_pkg::word_t   pc;
    rv_pkg::retire_t retire;
    int              issued;
    int              errors;

    rv_core dut0 (
        .clk         (clk),
        .rst         (rst),
        .instr       (instr),
        .instr_valid (instr_valid),
        .pc          (pc),
        .retire      (retire)
    );

    bind rv_core rv_core_assertions checks0 (
        .clk         (clk),
        .rst         (rst),
        .instr       (instr),
        .instr_valid (instr_valid),
        .pc          (pc),
        .retire      (retire),
        .regs        (reg_file0.regs)
    );

    function automatic rv_pkg::word_t r_type(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                             logic [2:0] f3, logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic rv_pkg::word_t i_type(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                             logic [4:0] rd, logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic rv_pkg::word_t s_type(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                             logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
    endfunction

    function automatic rv_pkg::word_t b_type(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                             logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic rv_pkg::word_t u_type(logic [19:0] imm, logic [4:0] rd, logic [6:0] op);
        return {imm, rd, op};
    endfunction

    function automatic rv_pkg::word_t j_type(logic [20:0] imm, logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    function automatic logic [4:0] rand_reg();
        return 5'($urandom_range(31));
    endfunction

    task automatic issue(input rv_pkg::word_t w);
        @(posedge clk);
        #1;
        instr       = w;
        instr_valid = 1'b1;
        issued++;
    endtask

    // occasional idle cycle with a junk lui on instr
    task automatic maybe_idle();
        if ($urandom_range(7) == 0) begin
            @(posedge clk);
            #1;
            instr_valid = 1'b0;
            instr       = {25'($urandom), rv_pkg::OP_LUI};
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        logic [4:0]  rs1;
        logic [2:0]  f3;
        logic [11:0] imm;
        logic [9:0]  addr;
        logic [1:0]  width;
        logic        alt;
        int unsigned sel;

        void'($urandom(32'h4b5f));
        rst         = 1'b1;
        instr       = '0;
        instr_valid = 1'b0;
        issued      = 0;
        errors      = 0;
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        repeat (2) @(posedge clk);

        // constants into every register
        for (int r = 1; r < 32; r++) begin
            issue(u_type(20'($urandom), 5'(r), rv_pkg::OP_LUI));
            issue(i_type(12'($urandom), 5'(r), 3'd0, 5'(r), rv_pkg::OP_ALUI));
        end
        issue(u_type(20'h00001, 5'd4, rv_pkg::OP_AUIPC));
        issue(i_type(12'h07b, 5'd0, 3'd0, 5'd0, rv_pkg::OP_ALUI));
        issue(32'h0000_000f);
        issue(32'h0000_0073);

        for (int n = 0; n < N_ALU; n++) begin
            f3  = 3'($urandom_range(7));
            alt = ((f3 == 3'd0) || (f3 == 3'd5)) && ($urandom_range(1) == 1);
            if ($urandom_range(1) == 1) begin
                issue(r_type({1'b0, alt, 5'b0}, rand_reg(), rand_reg(), f3, rand_reg()));
            end else begin
                imm = 12'($urandom);
                // shift immediates carry only shamt and the arithmetic bit
                if (f3 == 3'd1 || f3 == 3'd5) begin
                    imm = {1'b0, alt, 5'b0, imm[4:0]};
                end
                issue(i_type(imm, rand_reg(), f3, rand_reg(), rv_pkg::OP_ALUI));
            end
            maybe_idle();
        end

        for (int n = 0; n < N_MUL; n++) begin
            issue(r_type(7'h01, rand_reg(), rand_reg(), 3'($urandom_range(3)), rand_reg()));
            maybe_idle();
        end

        for (int n = 0; n < N_MEM; n++) begin
            width = 2'($urandom_range(2));
            addr  = 10'($urandom);
            if (width == 2'd2) begin
                addr = {addr[9:2], 2'b00};
            end else if (width == 2'd1) begin
                addr = {addr[9:1], 1'b0};
            end
            issue(s_type({2'b00, addr}, rand_reg(), 5'd0, {1'b0, width}));
            maybe_idle();
            // lw has no unsigned form
            f3 = {(width != 2'd2) && ($urandom_range(1) == 1), width};
            issue(i_type({2'b00, addr}, 5'd0, f3, rand_reg(), rv_pkg::OP_LOAD));
        end

        for (int n = 0; n < N_BRANCH; n++) begin
            case ($urandom_range(2))
                0: begin
                    sel = $urandom_range(5);
                    f3  = (sel < 2) ? 3'(sel) : 3'(sel + 2);
                    rs1 = rand_reg();
                    issue(b_type({12'($urandom), 1'b0},
                                 ($urandom_range(3) == 0) ? rs1 : rand_reg(), rs1, f3));
                end
                1: begin
                    issue(j_type({20'($urandom), 1'b0}, rand_reg()));
                end
                default: begin
                    issue(i_type(12'($urandom), rand_reg(), 3'd0, rand_reg(), rv_pkg::OP_JALR));
                end
            endcase
            maybe_idle();
        end

        @(posedge clk);
        #1;
        instr_valid = 1'b0;
        repeat (3) @(posedge clk);
        errors = dut0.checks0.fail_count;
        $display("closing: %0d instructions issued, %0d assertion failures", issued, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("closing: %0d instructions issued, %0d assertion failures, 1 timeout",
                 issued, dut0.checks0.fail_count);
        $display("Result: FAILED");
        $finish;
    end

endmodule
